// File: mem_bridge_top.f
map_pkg.sv
bus_pkg.sv
sram_bank.sv
uart_regs.sv
data_access_ctl.sv
bus_arbiter.sv
mem_bridge_top.sv
tb_mem_bridge_top.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := -sv --assert --timing
TOP       := mem_bridge_top
TB_TOP    := tb_mem_bridge_top
FLIST     := mem_bridge_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TB_TOP)
	./$(OBJ_DIR)/sim_$(TB_TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_mem_bridge_top.sv
`timescale 1ns/10ps

module tb_mem_bridge_top;

    typedef enum logic [2:0] {
        OP_LOAD,
        OP_STORE,
        OP_FETCH,
        OP_FETCH_DURING,   // data store, then a fetch while it is in flight
        OP_RX,
        OP_TX_BUSY
    } op_t;

    typedef struct packed {
        op_t                op;
        bus_pkg::addr_t     addr;      // data side, or fetch for OP_FETCH
        bus_pkg::addr_t     addr2;     // fetch address for OP_FETCH_DURING
        bus_pkg::word_t     data;
        bus_pkg::be_n_t     be_n;
        bus_pkg::word_t     exp_val;
        logic               flag;      // tx pulse expected, or grant expected
    } step_t;

    localparam int RESET_CYCLES = 10;
    localparam int OK_LIMIT     = 8;
    localparam int GNT_LIMIT    = 8;
    localparam bus_pkg::addr_t EXT_A   = 32'h8040_0040;   // bit 22 set
    localparam bus_pkg::addr_t BASE_A  = 32'h8000_0100;
    localparam bus_pkg::addr_t BASE_B  = 32'h8000_0104;
    localparam bus_pkg::addr_t UNMAPPED = 32'h1000_0000;
    localparam bus_pkg::word_t TX_RDY  = 32'd1 << map_pkg::STAT_TX_READY_BIT;
    localparam bus_pkg::word_t RX_AV   = 32'd1 << map_pkg::STAT_RX_AVAIL_BIT;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              ifu_req;
    bus_pkg::addr_t    ifu_addr;
    logic              ifu_gnt;
    logic              ifu_rvalid;
    bus_pkg::word_t    ifu_rdata;
    bus_pkg::mem_req_t dm_req;
    logic              dm_ok;
    bus_pkg::word_t    dm_rdata;
    logic              rx_strobe;
    bus_pkg::byte_t    rx_data;
    logic              tx_busy;
    logic              tx_start;
    bus_pkg::byte_t    tx_data;

    step_t  steps[$];
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit;
    int     cur_step = -1;

    mem_bridge_top dut (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .ifu_req_i        (ifu_req),
        .ifu_addr_i       (ifu_addr),
        .ifu_gnt_o        (ifu_gnt),
        .ifu_rvalid_o     (ifu_rvalid),
        .ifu_rdata_o      (ifu_rdata),
        .dm_req_i         (dm_req),
        .dm_ok_o          (dm_ok),
        .dm_rdata_o       (dm_rdata),
        .uart_rx_strobe_i (rx_strobe),
        .uart_rx_data_i   (rx_data),
        .uart_tx_busy_i   (tx_busy),
        .uart_tx_start_o  (tx_start),
        .uart_tx_data_o   (tx_data)
    );

    always #4 clk = ~clk;

    task automatic close_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d cycles in step %0d", cycle_limit, cur_step);
            errors++;
            close_run();
        end
    end

    task automatic check_val(input string name, input bus_pkg::word_t got,
                             input bus_pkg::word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR step %0d: %s got %h expected %h", cur_step, name, got, want);
        end
    endtask

    task automatic add_step(input op_t op, input bus_pkg::addr_t addr,
                            input bus_pkg::addr_t addr2, input bus_pkg::word_t data,
                            input bus_pkg::be_n_t be_n, input bus_pkg::word_t exp_val,
                            input logic flag);
        step_t s;
        s.op      = op;
        s.addr    = addr;
        s.addr2   = addr2;
        s.data    = data;
        s.be_n    = be_n;
        s.exp_val = exp_val;
        s.flag    = flag;
        steps.push_back(s);
    endtask

    task automatic build_table();
        bus_pkg::word_t w1;
        bus_pkg::word_t w2;
        bus_pkg::word_t w3;
        bus_pkg::word_t w4;
        bus_pkg::word_t w5;
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        w4 = $random(seed);
        w5 = $random(seed);
        // ext bank, full word then a partial overwrite
        add_step(OP_STORE, EXT_A, '0, w1, 4'b0000, '0, 1'b0);
        add_step(OP_LOAD,  EXT_A, '0, '0, 4'b0000, w1, 1'b0);
        add_step(OP_STORE, EXT_A, '0, w2, 4'b1010, '0, 1'b0);
        // be_n 4'b1010 opens lanes 0 and 2
        add_step(OP_LOAD,  EXT_A, '0, '0, 4'b0000,
                 (w1 & 32'hff00_ff00) | (w2 & 32'h00ff_00ff), 1'b0);
        // data store seen by fetch
        add_step(OP_STORE, BASE_A, '0, w3, 4'b0000, '0, 1'b0);
        add_step(OP_FETCH, BASE_A, '0, '0, 4'b0000, w3, 1'b0);
        // base conflict stalls fetch, ext access does not
        add_step(OP_FETCH_DURING, BASE_B, BASE_A, w4, 4'b0000, w3, 1'b0);
        add_step(OP_FETCH, BASE_B, '0, '0, 4'b0000, w4, 1'b0);
        add_step(OP_FETCH_DURING, EXT_A, BASE_A, w5, 4'b0000, w3, 1'b1);
        add_step(OP_LOAD,  EXT_A, '0, '0, 4'b0000, w5, 1'b0);
        // transmit side
        add_step(OP_TX_BUSY, '0, '0, 32'd0, 4'b0000, '0, 1'b0);
        add_step(OP_LOAD,  map_pkg::UART_STAT_ADDR, '0, '0, 4'b0000, TX_RDY, 1'b0);
        add_step(OP_STORE, map_pkg::UART_DATA_ADDR, '0, 32'h1234_005a, 4'b0000, '0, 1'b1);
        add_step(OP_TX_BUSY, '0, '0, 32'd1, 4'b0000, '0, 1'b0);
        add_step(OP_LOAD,  map_pkg::UART_STAT_ADDR, '0, '0, 4'b0000, 32'd0, 1'b0);
        add_step(OP_STORE, map_pkg::UART_DATA_ADDR, '0, 32'h0000_00a7, 4'b0000, '0, 1'b0);
        add_step(OP_TX_BUSY, '0, '0, 32'd0, 4'b0000, '0, 1'b0);
        // receive side
        add_step(OP_RX, '0, '0, 32'h0000_003c, 4'b0000, '0, 1'b0);
        add_step(OP_LOAD,  map_pkg::UART_STAT_ADDR, '0, '0, 4'b0000, TX_RDY | RX_AV, 1'b0);
        add_step(OP_LOAD,  map_pkg::UART_DATA_ADDR, '0, '0, 4'b0000, 32'h0000_003c, 1'b0);
        add_step(OP_LOAD,  map_pkg::UART_STAT_ADDR, '0, '0, 4'b0000, TX_RDY, 1'b0);
        // nothing mapped here
        add_step(OP_LOAD,  UNMAPPED, '0, '0, 4'b0000, 32'd0, 1'b0);
        add_step(OP_FETCH, UNMAPPED, '0, '0, 4'b0000, 32'd0, 1'b0);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // entered just after an edge, request goes out now
    task automatic data_op(input step_t s);
        bus_pkg::mem_req_t req;
        int   waits;
        logic got_ok;
        req.rd    = (s.op == OP_LOAD);
        req.wr    = (s.op == OP_STORE);
        req.addr  = s.addr;
        req.be_n  = s.be_n;
        req.wdata = s.data;
        dm_req = req;
        waits  = 0;
        got_ok = 1'b0;
        while (!got_ok && waits < OK_LIMIT) begin
            tick();
            waits++;
            got_ok = dm_ok;
        end
        if (!got_ok) begin
            errors++;
            $display("step %0d: dm_ok_o never pulsed within %0d cycles", cur_step, OK_LIMIT);
        end else begin
            check_val("dm_ok_o latency", waits, 32'd2);   // second edge after the request
            if (s.op == OP_LOAD) begin
                check_val("dm_rdata_o", dm_rdata, s.exp_val);
            end else begin
                check_val("uart_tx_start_o", 32'(tx_start), 32'(s.flag));
                if (s.flag) begin
                    check_val("uart_tx_data_o", 32'(tx_data), 32'(s.data[7:0]));
                end
            end
        end
        dm_req = '0;
        tick();
        check_val("dm_ok_o", 32'(dm_ok), 32'd0);       // single-cycle pulse
        check_val("uart_tx_start_o", 32'(tx_start), 32'd0);
    endtask

    // request already on the port, retry until granted
    task automatic finish_fetch(input bus_pkg::word_t want);
        int   tries;
        logic g;
        logic done;
        tries = 0;
        done  = 1'b0;
        while (!done && tries < GNT_LIMIT) begin
            @(negedge clk);
            g = ifu_gnt;
            tick();
            tries++;
            if (g) begin
                check_val("ifu_rvalid_o", 32'(ifu_rvalid), 32'd1);
                check_val("ifu_rdata_o", ifu_rdata, want);
                done = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("step %0d: fetch of %h was never granted", cur_step, ifu_addr);
        end
        ifu_req = 1'b0;
    endtask

    task automatic fetch_during(input step_t s);
        bus_pkg::mem_req_t req;
        logic g;
        req.rd    = 1'b0;
        req.wr    = 1'b1;
        req.addr  = s.addr;
        req.be_n  = s.be_n;
        req.wdata = s.data;
        dm_req = req;
        tick();                       // captured, controller now in access
        ifu_req  = 1'b1;
        ifu_addr = s.addr2;
        @(negedge clk);
        g = ifu_gnt;
        check_val("ifu_gnt_o", 32'(g), 32'(s.flag));
        tick();
        check_val("dm_ok_o", 32'(dm_ok), 32'd1);
        dm_req = '0;
        if (g) begin
            check_val("ifu_rvalid_o", 32'(ifu_rvalid), 32'd1);
            check_val("ifu_rdata_o", ifu_rdata, s.exp_val);
            ifu_req = 1'b0;
        end else begin
            finish_fetch(s.exp_val);
        end
        tick();
    endtask

    initial begin
        seed      = 32'h80b7;
        rst_n     = 1'b0;
        ifu_req   = 1'b0;
        ifu_addr  = '0;
        dm_req    = '0;
        rx_strobe = 1'b0;
        rx_data   = '0;
        tx_busy   = 1'b0;
        build_table();
        cycle_limit = RESET_CYCLES + steps.size() * 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_val("dm_ok_o", 32'(dm_ok), 32'd0);
        check_val("ifu_rvalid_o", 32'(ifu_rvalid), 32'd0);
        check_val("uart_tx_start_o", 32'(tx_start), 32'd0);
        foreach (steps[i]) begin
            cur_step = i;
            case (steps[i].op)
                OP_LOAD, OP_STORE: data_op(steps[i]);
                OP_FETCH: begin
                    ifu_req  = 1'b1;
                    ifu_addr = steps[i].addr;
                    finish_fetch(steps[i].exp_val);
                    tick();
                end
                OP_FETCH_DURING: fetch_during(steps[i]);
                OP_RX: begin
                    rx_strobe = 1'b1;
                    rx_data   = steps[i].data[7:0];
                    tick();
                    rx_strobe = 1'b0;
                end
                default: begin
                    tx_busy = steps[i].data[0];
                    tick();
                end
            endcase
        end
        close_run();
    end

endmodule

// File: mem_bridge_top.sv
`timescale 1ns/10ps

module mem_bridge_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              ifu_req_i,
    input  bus_pkg::addr_t    ifu_addr_i,
    output logic              ifu_gnt_o,
    output logic              ifu_rvalid_o,
    output bus_pkg::word_t    ifu_rdata_o,
    input  bus_pkg::mem_req_t dm_req_i,
    output logic              dm_ok_o,
    output bus_pkg::word_t    dm_rdata_o,
    input  logic              uart_rx_strobe_i,
    input  bus_pkg::byte_t    uart_rx_data_i,
    input  logic              uart_tx_busy_i,
    output logic              uart_tx_start_o,
    output bus_pkg::byte_t    uart_tx_data_o
);

    bus_pkg::mem_req_t  lsu_req;
    logic               lsu_busy;
    bus_pkg::word_t     lsu_rdata;
    bus_pkg::bank_req_t base_req;
    bus_pkg::bank_req_t ext_req;
    bus_pkg::word_t     base_rdata;
    bus_pkg::word_t     ext_rdata;
    logic               uart_rd;
    logic               uart_wr;
    logic               uart_sel_stat;
    bus_pkg::byte_t     uart_wdata;
    bus_pkg::word_t     uart_rdata;

    data_access_ctl u_dctl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .dm_req_i    (dm_req_i),
        .dm_ok_o     (dm_ok_o),
        .dm_rdata_o  (dm_rdata_o),
        .lsu_req_o   (lsu_req),
        .lsu_busy_o  (lsu_busy),
        .lsu_rdata_i (lsu_rdata)
    );

    // fetch and data meet here as peers
    bus_arbiter u_arb (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ifu_req_i       (ifu_req_i),
        .ifu_addr_i      (ifu_addr_i),
        .ifu_gnt_o       (ifu_gnt_o),
        .ifu_rvalid_o    (ifu_rvalid_o),
        .ifu_rdata_o     (ifu_rdata_o),
        .lsu_req_i       (lsu_req),
        .lsu_busy_i      (lsu_busy),
        .lsu_rdata_o     (lsu_rdata),
        .base_req_o      (base_req),
        .base_rdata_i    (base_rdata),
        .ext_req_o       (ext_req),
        .ext_rdata_i     (ext_rdata),
        .uart_rd_o       (uart_rd),
        .uart_wr_o       (uart_wr),
        .uart_sel_stat_o (uart_sel_stat),
        .uart_wdata_o    (uart_wdata),
        .uart_rdata_i    (uart_rdata)
    );

    sram_bank base_bank (
        .clk_i   (clk_i),
        .req_i   (base_req),
        .rdata_o (base_rdata)
    );

    sram_bank ext_bank (
        .clk_i   (clk_i),
        .req_i   (ext_req),
        .rdata_o (ext_rdata)
    );

    uart_regs u_uart (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_i        (uart_rd),
        .wr_i        (uart_wr),
        .sel_stat_i  (uart_sel_stat),
        .wdata_i     (uart_wdata),
        .rdata_o     (uart_rdata),
        .rx_strobe_i (uart_rx_strobe_i),
        .rx_data_i   (uart_rx_data_i),
        .tx_busy_i   (uart_tx_busy_i),
        .tx_start_o  (uart_tx_start_o),
        .tx_data_o   (uart_tx_data_o)
    );

endmodule

// File: bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               ifu_req_i,
    input  bus_pkg::addr_t     ifu_addr_i,
    output logic               ifu_gnt_o,
    output logic               ifu_rvalid_o,
    output bus_pkg::word_t     ifu_rdata_o,
    input  bus_pkg::mem_req_t  lsu_req_i,
    input  logic               lsu_busy_i,
    output bus_pkg::word_t     lsu_rdata_o,
    output bus_pkg::bank_req_t base_req_o,
    input  bus_pkg::word_t     base_rdata_i,
    output bus_pkg::bank_req_t ext_req_o,
    input  bus_pkg::word_t     ext_rdata_i,
    output logic               uart_rd_o,
    output logic               uart_wr_o,
    output logic               uart_sel_stat_o,
    output bus_pkg::byte_t     uart_wdata_o,
    input  bus_pkg::word_t     uart_rdata_i
);

    function automatic bus_pkg::target_t decode(bus_pkg::addr_t a);
        if (a[31:map_pkg::RAM_WIN_BIT] == map_pkg::RAM_BASE[31:map_pkg::RAM_WIN_BIT]) begin
            return a[map_pkg::EXT_SEL_BIT] ? bus_pkg::TGT_EXT : bus_pkg::TGT_BASE;
        end
        if (a == map_pkg::UART_DATA_ADDR) begin
            return bus_pkg::TGT_UDATA;
        end
        if (a == map_pkg::UART_STAT_ADDR) begin
            return bus_pkg::TGT_USTAT;
        end
        return bus_pkg::TGT_NONE;
    endfunction

    function automatic bus_pkg::bank_req_t to_bank(bus_pkg::mem_req_t r);
        bus_pkg::bank_req_t b;
        b.rd    = r.rd;
        b.wr    = r.wr;
        b.idx   = r.addr[map_pkg::BANK_AW+1:2];   // word index, upper bits alias
        b.be_n  = r.be_n;
        b.wdata = r.wdata;
        return b;
    endfunction

    logic              lsu_act;
    logic              ifu_ram;
    bus_pkg::target_t  lsu_tgt;
    bus_pkg::target_t  ifu_tgt;
    bus_pkg::target_t  dm_tgt_q;
    bus_pkg::target_t  ifu_tgt_q;
    bus_pkg::mem_req_t ifu_as_req;

    assign lsu_act = lsu_req_i.rd | lsu_req_i.wr;
    assign lsu_tgt = lsu_act ? decode(lsu_req_i.addr) : bus_pkg::TGT_NONE;
    assign ifu_tgt = decode(ifu_addr_i);
    assign ifu_ram = (ifu_tgt == bus_pkg::TGT_BASE) || (ifu_tgt == bus_pkg::TGT_EXT);

    // data side wins; fetch only loses to a data access on its own bank
    assign ifu_gnt_o = ifu_req_i && !(ifu_ram && (ifu_tgt == lsu_tgt));

    assign ifu_as_req = '{rd: 1'b1, wr: 1'b0, addr: ifu_addr_i, be_n: '0, wdata: '0};

    always_comb begin
        base_req_o = '0;
        ext_req_o  = '0;
        if (lsu_tgt == bus_pkg::TGT_BASE) begin
            base_req_o = to_bank(lsu_req_i);
        end else if (ifu_gnt_o && ifu_tgt == bus_pkg::TGT_BASE) begin
            base_req_o = to_bank(ifu_as_req);
        end
        if (lsu_tgt == bus_pkg::TGT_EXT) begin
            ext_req_o = to_bank(lsu_req_i);
        end else if (ifu_gnt_o && ifu_tgt == bus_pkg::TGT_EXT) begin
            ext_req_o = to_bank(ifu_as_req);
        end
    end

    // serial registers only reachable from the data side
    assign uart_rd_o       = lsu_req_i.rd && (lsu_tgt inside {bus_pkg::TGT_UDATA,
                                                              bus_pkg::TGT_USTAT});
    assign uart_wr_o       = lsu_req_i.wr && (lsu_tgt inside {bus_pkg::TGT_UDATA,
                                                              bus_pkg::TGT_USTAT});
    assign uart_sel_stat_o = (lsu_tgt == bus_pkg::TGT_USTAT);
    assign uart_wdata_o    = lsu_req_i.wdata[7:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dm_tgt_q     <= bus_pkg::TGT_NONE;
            ifu_tgt_q    <= bus_pkg::TGT_NONE;
            ifu_rvalid_o <= 1'b0;
        end else begin
            dm_tgt_q     <= lsu_tgt;
            ifu_tgt_q    <= ifu_gnt_o ? ifu_tgt : bus_pkg::TGT_NONE;
            ifu_rvalid_o <= ifu_gnt_o;
        end
    end

    // steer next-cycle read data by where each side went
    always_comb begin
        case (dm_tgt_q)
            bus_pkg::TGT_BASE:  lsu_rdata_o = base_rdata_i;
            bus_pkg::TGT_EXT:   lsu_rdata_o = ext_rdata_i;
            bus_pkg::TGT_UDATA: lsu_rdata_o = uart_rdata_i;
            bus_pkg::TGT_USTAT: lsu_rdata_o = uart_rdata_i;
            default:            lsu_rdata_o = '0;     // unmapped
        endcase
    end

    always_comb begin
        case (ifu_tgt_q)
            bus_pkg::TGT_BASE: ifu_rdata_o = base_rdata_i;
            bus_pkg::TGT_EXT:  ifu_rdata_o = ext_rdata_i;
            default:           ifu_rdata_o = '0;      // fetch outside the ram window
        endcase
    end

    // both sides never collect data from the same bank in one cycle
    a_no_bank_share: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ifu_rvalid_o && ifu_tgt_q inside {bus_pkg::TGT_BASE, bus_pkg::TGT_EXT})
        |-> (ifu_tgt_q != dm_tgt_q));

    // data strobes only come while the controller owns an access
    a_lsu_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_act |-> lsu_busy_i);

endmodule

// File: data_access_ctl.sv
`timescale 1ns/10ps

module data_access_ctl (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  bus_pkg::mem_req_t dm_req_i,
    output logic              dm_ok_o,
    output bus_pkg::word_t    dm_rdata_o,
    output bus_pkg::mem_req_t lsu_req_o,
    output logic              lsu_busy_o,
    input  bus_pkg::word_t    lsu_rdata_i
);

    bus_pkg::ctl_state_t state_q;
    bus_pkg::ctl_state_t state_d;
    bus_pkg::mem_req_t   req_q;
    logic                req_hit;

    assign req_hit = dm_req_i.rd | dm_req_i.wr;

    // idle -> access -> respond, one cycle each after capture
    always_comb begin
        state_d = state_q;
        case (state_q)
            bus_pkg::CTL_IDLE: begin
                if (req_hit) begin
                    state_d = bus_pkg::CTL_ACCESS;
                end
            end
            bus_pkg::CTL_ACCESS:  state_d = bus_pkg::CTL_RESPOND;
            bus_pkg::CTL_RESPOND: state_d = bus_pkg::CTL_IDLE;   // no recapture here
            default:              state_d = bus_pkg::CTL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= bus_pkg::CTL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // hold a copy so the requester bus is free to move
    always_ff @(posedge clk_i) begin
        if (state_q == bus_pkg::CTL_IDLE && req_hit) begin
            req_q <= dm_req_i;
        end
    end

    assign lsu_req_o  = (state_q == bus_pkg::CTL_ACCESS) ? req_q : '0;
    assign lsu_busy_o = (state_q != bus_pkg::CTL_IDLE);
    assign dm_ok_o    = (state_q == bus_pkg::CTL_RESPOND);
    assign dm_rdata_o = dm_ok_o ? lsu_rdata_i : '0;    // arbiter already steered it

    // a strobe reaches the arbiter only in the cycle after capture and unchanged
    a_strobe_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lsu_req_o.rd || lsu_req_o.wr)
        |-> ($past(state_q) == bus_pkg::CTL_IDLE) && (lsu_req_o == $past(dm_req_i)));

endmodule

// File: uart_regs.sv
`timescale 1ns/10ps

module uart_regs (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           rd_i,
    input  logic           wr_i,
    input  logic           sel_stat_i,    // 1 = status, 0 = data
    input  bus_pkg::byte_t wdata_i,
    output bus_pkg::word_t rdata_o,
    input  logic           rx_strobe_i,
    input  bus_pkg::byte_t rx_data_i,
    input  logic           tx_busy_i,
    output logic           tx_start_o,
    output bus_pkg::byte_t tx_data_o
);

    bus_pkg::byte_t rx_buf_q;
    logic           rx_avail_q;
    bus_pkg::word_t stat_word;
    logic           tx_fire;

    always_comb begin
        stat_word = '0;
        stat_word[map_pkg::STAT_TX_READY_BIT] = ~tx_busy_i;
        stat_word[map_pkg::STAT_RX_AVAIL_BIT] = rx_avail_q;
    end

    // writes while the transmitter is busy are lost
    assign tx_fire = wr_i && !sel_stat_i && !tx_busy_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_avail_q <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            if (rx_strobe_i) begin
                rx_avail_q <= 1'b1;          // new byte beats a clearing read
            end else if (rd_i && !sel_stat_i) begin
                rx_avail_q <= 1'b0;
            end
            tx_start_o <= tx_fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_strobe_i) begin
            rx_buf_q <= rx_data_i;            // newest byte overwrites
        end
        if (tx_fire) begin
            tx_data_o <= wdata_i;
        end
        if (rd_i) begin
            rdata_o <= sel_stat_i ? stat_word : {24'd0, rx_buf_q};
        end
    end

endmodule

// File: sram_bank.sv
`timescale 1ns/10ps

module sram_bank #(
    parameter int AW = map_pkg::BANK_AW
) (
    input  logic               clk_i,
    input  bus_pkg::bank_req_t req_i,
    output bus_pkg::word_t     rdata_o
);

    bus_pkg::word_t mem [2**AW];
    logic [AW-1:0] idx;

    assign idx = req_i.idx[AW-1:0];

    // byte lanes written where be_n is low
    always_ff @(posedge clk_i) begin
        if (req_i.wr) begin
            for (int b = 0; b < $bits(bus_pkg::be_n_t); b++) begin
                if (!req_i.be_n[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, holds last word when idle
    always_ff @(posedge clk_i) begin
        if (req_i.rd) begin
            rdata_o <= mem[idx];
        end
    end

    // the arbiter hands a bank either a load or a store, never a mix
    a_no_rd_wr: assert property (@(posedge clk_i) !(req_i.rd && req_i.wr));

endmodule

// File: bus_pkg.sv
package bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [3:0]  be_n_t;     // low = lane written
    typedef logic [7:0]  byte_t;     // serial payload
    typedef logic [map_pkg::BANK_AW-1:0] bank_idx_t;   // word index inside one bank

    // request on any shared path
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        be_n_t be_n;
        word_t wdata;
    } mem_req_t;

    // request seen by one bank
    typedef struct packed {
        logic      rd;
        logic      wr;
        bank_idx_t idx;
        be_n_t     be_n;
        word_t     wdata;
    } bank_req_t;

    typedef enum logic [2:0] {
        TGT_BASE,
        TGT_EXT,
        TGT_UDATA,
        TGT_USTAT,
        TGT_NONE
    } target_t;

    typedef enum logic [1:0] {
        CTL_IDLE,
        CTL_ACCESS,
        CTL_RESPOND
    } ctl_state_t;

endpackage

// File: map_pkg.sv
package map_pkg;

    // one bank of on-chip storage, 1024 words
    localparam int BANK_AW = 10;

    // sram window, 8 MB starting here
    localparam logic [31:0] RAM_BASE = 32'h8000_0000;
    localparam int RAM_WIN_BIT = 23;      // upper bits above this must match RAM_BASE

    // picks ext bank over base bank inside the window
    localparam int EXT_SEL_BIT = 22;

    // memory-mapped serial port
    localparam logic [31:0] UART_DATA_ADDR = 32'hbfd0_03f8;
    localparam logic [31:0] UART_STAT_ADDR = 32'hbfd0_03fc;

    // status word layout
    localparam int STAT_TX_READY_BIT = 0;   // transmitter idle
    localparam int STAT_RX_AVAIL_BIT = 1;   // unread byte in rx buffer

endpackage
